//--- src/spi_memory_settings.svh
// Sizes for the SPI byte memory; the command byte is ADDR_WIDTH address bits plus one R/W bit
`ifndef SPI_MEMORY_SETTINGS_SVH
`define SPI_MEMORY_SETTINGS_SVH

// Address bits carried in the command byte
`define SPI_ADDR_WIDTH 7

// Word width, also the number of serial bits per phase
`define SPI_DATA_WIDTH 8

// One word per address
`define SPI_MEM_DEPTH 128

// Flip-flops per pin in the input synchronizer, at least 2
`define SPI_SYNC_STAGES 2

`endif

//--- src/spi_memory_pkg.sv
// Types shared by the SPI byte memory; struct field order is part of the pin interface
`default_nettype none

package spi_memory_pkg;

    // Raw pins from the external SPI master
    typedef struct packed {
        logic sclk;
        logic cs;
        logic mosi;
    } spi_pins_t;

    // Pins after synchronization to clkedge
    typedef struct packed {
        logic sclk_rise;
        logic sclk_fall;
        logic cs;
        logic mosi;
    } spi_cond_t;

    // Strobes and levels from the control FSM
    typedef struct packed {
        logic addr_we;
        logic sr_we;
        logic dm_we;
        logic miso_bufe;
    } spi_ctrl_t;

    typedef enum logic [2:0] {
        GET, GOT, READ1, READ2, READ3, WRITE1, WRITE2, DONE
    } spi_state_t;

endpackage

`default_nettype wire

//--- src/input_conditioner.sv
// Edge pulses lag the pin by SPI_SYNC_STAGES+1 cycles; sclk edges need 8+ cycles of spacing
`default_nettype none

`include "spi_memory_settings.svh"

module input_conditioner
    import spi_memory_pkg::*;
(
    input  logic      clkedge,
    input  logic      rst_n,
    input  spi_pins_t pins,
    output spi_cond_t cond
);

    // Idle bus: chip deselected, clock low
    localparam spi_pins_t PINS_IDLE = '{sclk: 1'b0, cs: 1'b1, mosi: 1'b0};

    spi_pins_t [`SPI_SYNC_STAGES-1:0] sync_q;
    spi_pins_t                        pins_s;
    logic                             sclk_prev;
    logic                             rise_q;
    logic                             fall_q;

    // Stage 0 takes the raw pins, the top stage is the clean copy
    always_ff @(posedge clkedge) begin
        if (!rst_n) begin
            sync_q <= {`SPI_SYNC_STAGES{PINS_IDLE}};
        end else begin
            sync_q <= {sync_q[`SPI_SYNC_STAGES-2:0], pins};
        end
    end

    assign pins_s = sync_q[`SPI_SYNC_STAGES-1];

    // Edge detect on the synchronized clock
    always_ff @(posedge clkedge) begin
        if (!rst_n) begin
            sclk_prev <= 1'b0;
            rise_q    <= 1'b0;
            fall_q    <= 1'b0;
        end else begin
            sclk_prev <= pins_s.sclk;
            rise_q    <= pins_s.sclk & ~sclk_prev;
            fall_q    <= ~pins_s.sclk & sclk_prev;
        end
    end

    assign cond.sclk_rise = rise_q;
    assign cond.sclk_fall = fall_q;
    assign cond.cs        = pins_s.cs;
    assign cond.mosi      = pins_s.mosi;

endmodule

`default_nettype wire

//--- src/shift_register.sv
// Mode 0 shifter; parallel load wins over a shift, serial_out moves only on falling sclk
`default_nettype none

`include "spi_memory_settings.svh"

module shift_register (
    input  logic                       clkedge,
    input  logic                       rst_n,
    input  logic                       shift_in_en,
    input  logic                       shift_out_en,
    input  logic                       serial_in,
    input  logic                       load,
    input  logic [`SPI_DATA_WIDTH-1:0] parallel_in,
    output logic [`SPI_DATA_WIDTH-1:0] parallel_out,
    output logic                       serial_out
);

    logic [`SPI_DATA_WIDTH-1:0] data_q;
    logic                       serial_q;

    // MSB first, new bits enter at the LSB
    always_ff @(posedge clkedge) begin
        if (load) begin
            data_q <= parallel_in;
        end else if (shift_in_en) begin
            data_q <= {data_q[`SPI_DATA_WIDTH-2:0], serial_in};
        end
    end

    // Present the MSB half a bit ahead of the master's sampling edge
    always_ff @(posedge clkedge) begin
        if (!rst_n) begin
            serial_q <= 1'b0;
        end else if (shift_out_en) begin
            serial_q <= data_q[`SPI_DATA_WIDTH-1];
        end
    end

    assign parallel_out = data_q;
    assign serial_out   = serial_q;

endmodule

`default_nettype wire

//--- src/data_memory.sv
// Byte array with combinational read; contents are undefined until written
`default_nettype none

`include "spi_memory_settings.svh"

module data_memory (
    input  logic                       clkedge,
    input  logic [`SPI_ADDR_WIDTH-1:0] addr,
    input  logic                       we,
    input  logic [`SPI_DATA_WIDTH-1:0] wdata,
    output logic [`SPI_DATA_WIDTH-1:0] rdata
);

    logic [`SPI_DATA_WIDTH-1:0] mem [0:`SPI_MEM_DEPTH-1];

    always_ff @(posedge clkedge) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // Read and write share the one address
    assign rdata = mem[addr];

endmodule

`default_nettype wire

//--- src/spi_control_fsm.sv
// Single-byte transactions only; synchronized cs high aborts from any state without a write
`default_nettype none

`include "spi_memory_settings.svh"

module spi_control_fsm
    import spi_memory_pkg::*;
(
    input  logic      clkedge,
    input  logic      rst_n,
    input  spi_cond_t cond,
    input  logic      rw_bit,
    output spi_ctrl_t ctrl
);

    // Index of the last bit in a byte
    localparam logic [3:0] LAST_BIT = 4'(`SPI_DATA_WIDTH - 1);
    // Read ends on the fall after the last data bit, once the master has sampled it
    localparam logic [3:0] READ_FALLS = 4'(`SPI_DATA_WIDTH);

    spi_state_t state;
    logic [3:0] count;

    always_ff @(posedge clkedge) begin
        if (!rst_n) begin
            state <= GET;
            count <= '0;
        end else if (cond.cs) begin
            state <= GET;
            count <= '0;
        end else begin
            case (state)
                GET: begin
                    if (cond.sclk_rise) begin
                        if (count == LAST_BIT) begin
                            count <= '0;
                            state <= GOT;
                        end else begin
                            count <= count + 4'd1;
                        end
                    end
                end
                // LSB of the command byte is the R/W flag
                GOT: begin
                    state <= rw_bit ? READ1 : WRITE1;
                end
                // Latched address reaches the memory
                READ1: begin
                    state <= READ2;
                end
                READ2: begin
                    state <= READ3;
                end
                READ3: begin
                    if (cond.sclk_fall) begin
                        if (count == READ_FALLS) begin
                            count <= '0;
                            state <= DONE;
                        end else begin
                            count <= count + 4'd1;
                        end
                    end
                end
                WRITE1: begin
                    if (cond.sclk_rise) begin
                        if (count == LAST_BIT) begin
                            count <= '0;
                            state <= WRITE2;
                        end else begin
                            count <= count + 4'd1;
                        end
                    end
                end
                WRITE2: begin
                    state <= DONE;
                end
                // Stay until cs goes high
                DONE: begin
                    state <= DONE;
                end
                default: begin
                    state <= GET;
                end
            endcase
        end
    end

    // Outputs decode the state, so each strobe lasts exactly its state
    always_comb begin
        ctrl           = '0;
        ctrl.addr_we   = (state == GOT);
        ctrl.sr_we     = (state == READ2);
        ctrl.dm_we     = (state == WRITE2);
        ctrl.miso_bufe = (state == READ3) && !cond.cs;
    end

endmodule

`default_nettype wire

//--- src/spi_memory.sv
// SPI mode 0 slave memory; miso is valid only while miso_oe is high, no tristate pad
`default_nettype none

`include "spi_memory_settings.svh"

module spi_memory
    import spi_memory_pkg::*;
(
    input  logic      clkedge,
    input  logic      rst_n,
    input  spi_pins_t pins,
    output logic      miso,
    output logic      miso_oe
);

    spi_cond_t                  cond;
    spi_ctrl_t                  ctrl;
    logic [`SPI_DATA_WIDTH-1:0] sr_data;
    logic [`SPI_DATA_WIDTH-1:0] mem_rdata;
    logic [`SPI_ADDR_WIDTH-1:0] addr_q;
    logic                       sr_serial;

    input_conditioner i_cond (
        .clkedge (clkedge),
        .rst_n   (rst_n),
        .pins    (pins),
        .cond    (cond)
    );

    shift_register i_sr (
        .clkedge      (clkedge),
        .rst_n        (rst_n),
        .shift_in_en  (cond.sclk_rise),
        .shift_out_en (cond.sclk_fall),
        .serial_in    (cond.mosi),
        .load         (ctrl.sr_we),
        .parallel_in  (mem_rdata),
        .parallel_out (sr_data),
        .serial_out   (sr_serial)
    );

    // Upper bits of the command byte hold the address
    always_ff @(posedge clkedge) begin
        if (!rst_n) begin
            addr_q <= '0;
        end else if (ctrl.addr_we) begin
            addr_q <= sr_data[`SPI_DATA_WIDTH-1 -: `SPI_ADDR_WIDTH];
        end
    end

    data_memory i_mem (
        .clkedge (clkedge),
        .addr    (addr_q),
        .we      (ctrl.dm_we),
        .wdata   (sr_data),
        .rdata   (mem_rdata)
    );

    spi_control_fsm i_fsm (
        .clkedge (clkedge),
        .rst_n   (rst_n),
        .cond    (cond),
        .rw_bit  (sr_data[0]),
        .ctrl    (ctrl)
    );

    // Shifter output is already registered on the falling edge
    assign miso    = sr_serial;
    assign miso_oe = ctrl.miso_bufe;

endmodule

`default_nettype wire

//--- tb/spi_memory_asserts.sv
// Bound into spi_control_fsm; relies on its internal state register and its cond and ctrl ports
`default_nettype none

module spi_memory_asserts
    import spi_memory_pkg::*;
(
    input logic       clkedge,
    input logic       rst_n,
    input spi_cond_t  cond,
    input spi_ctrl_t  ctrl,
    input spi_state_t state
);

    int fail_count = 0;

    // Memory store is a single-cycle strobe
    dm_we_pulse: assert property (@(posedge clkedge) disable iff (!rst_n)
        ctrl.dm_we |=> !ctrl.dm_we)
    else begin
        fail_count++;
        $error("dm_we stayed high for more than one cycle");
    end

    // Shift register load is a single-cycle strobe
    sr_we_pulse: assert property (@(posedge clkedge) disable iff (!rst_n)
        ctrl.sr_we |=> !ctrl.sr_we)
    else begin
        fail_count++;
        $error("sr_we stayed high for more than one cycle");
    end

    // Deselected slave never drives MISO
    bufe_needs_cs: assert property (@(posedge clkedge) disable iff (!rst_n)
        !(ctrl.miso_bufe && cond.cs))
    else begin
        fail_count++;
        $error("miso_bufe high while chip select is high");
    end

    dm_we_in_write2: assert property (@(posedge clkedge) disable iff (!rst_n)
        ctrl.dm_we |-> state == WRITE2)
    else begin
        fail_count++;
        $error("dm_we high outside WRITE2");
    end

endmodule

bind spi_control_fsm spi_memory_asserts i_asserts (
    .clkedge (clkedge),
    .rst_n   (rst_n),
    .cond    (cond),
    .ctrl    (ctrl),
    .state   (state)
);

`default_nettype wire

//--- tb/spi_memory_tb.sv
// SPI mode 0 master at 10 clkedge cycles per half bit; reads only hit addresses already written
`default_nettype none

`include "spi_memory_settings.svh"

module spi_memory_tb
    import spi_memory_pkg::*;
();

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 5;
    localparam int IDLE_GAP     = 10;
    localparam int MIN_GAP      = 2;
    localparam int TAIL_CYCLES  = 6;
    localparam int NUM_XFERS    = 45;
    localparam int XFER_CYCLES  = 16 * 2 * HALF_PERIOD + TAIL_CYCLES + IDLE_GAP;
    localparam int TIMEOUT_CYCLES = NUM_XFERS * XFER_CYCLES + 1000;

    logic      clkedge = 1'b0;
    logic      rst_n;
    spi_pins_t pins;
    logic      miso;
    logic      miso_oe;

    logic [`SPI_DATA_WIDTH-1:0] ref_mem [0:`SPI_MEM_DEPTH-1];
    logic                       written [0:`SPI_MEM_DEPTH-1];
    logic [31:0]                lcg_state;
    logic [1:0]                 cs_seen;
    int                         cycle_count;

    spi_memory i_dut (
        .clkedge (clkedge),
        .rst_n   (rst_n),
        .pins    (pins),
        .miso    (miso),
        .miso_oe (miso_oe)
    );

    initial begin
        forever #5 clkedge = ~clkedge;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clkedge);
    endtask

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        assert (actual === expected) else begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    // One transaction; nbits below 16 cuts a write short by raising cs early
    task automatic spi_xfer(
        input  logic       is_read,
        input  logic [6:0] addr,
        input  logic [7:0] wdata,
        input  int         nbits,
        output logic [7:0] rdata
    );
        logic [15:0] frame;
        frame = {addr, is_read, wdata};
        rdata = '0;
        pins.cs = 1'b0;
        for (int i = 0; i < nbits; i++) begin
            pins.mosi = is_read && i >= 8 ? 1'b0 : frame[15 - i];
            wait_cycles(HALF_PERIOD);
            if (is_read && i >= 8) begin
                check_value("miso_oe", 8'h01, {7'b0, miso_oe});
                rdata = {rdata[6:0], miso};
            end
            pins.sclk = 1'b1;
            wait_cycles(HALF_PERIOD);
            pins.sclk = 1'b0;
        end
        wait_cycles(TAIL_CYCLES);
        check_value("miso_oe", 8'h00, {7'b0, miso_oe});
        pins.cs = 1'b1;
    endtask

    task automatic write_byte(input logic [6:0] addr, input logic [7:0] data, input int gap);
        logic [7:0] unused;
        spi_xfer(1'b0, addr, data, 16, unused);
        ref_mem[addr] = data;
        written[addr] = 1'b1;
        wait_cycles(gap);
    endtask

    task automatic read_and_check(input logic [6:0] addr, input int gap);
        logic [7:0] got;
        spi_xfer(1'b1, addr, 8'h00, 16, got);
        check_value("miso byte", ref_mem[addr], got);
        wait_cycles(gap);
    endtask

    // Pin cs as the synchronizer sees it, two samples deep
    always @(posedge clkedge) begin
        cs_seen <= {cs_seen[0], pins.cs};
    end

    always @(negedge clkedge) begin
        if (i_dut.i_fsm.i_asserts.fail_count != 0) begin
            $display("protocol assertion in the control FSM failed at %0t", $time);
            $display("TESTS FAILED");
            $fatal(1);
        end else if (cycle_count > 0 && (!rst_n || &cs_seen)) begin
            check_value("miso_oe", 8'h00, {7'b0, miso_oe});
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clkedge);
            cycle_count++;
        end
        $display("timeout after %0d cycles, transactions did not finish", cycle_count);
        $display("TESTS FAILED");
        $fatal(1);
    end

    initial begin
        logic [6:0] addr;
        logic [7:0] unused;
        pins.sclk = 1'b0;
        pins.cs   = 1'b1;
        pins.mosi = 1'b0;
        rst_n     = 1'b0;
        cs_seen   = 2'b00;
        lcg_state = 32'h893e_3f2b;
        for (int i = 0; i < `SPI_MEM_DEPTH; i++) begin
            written[i] = 1'b0;
        end
        wait_cycles(RESET_CYCLES);
        rst_n = 1'b1;
        wait_cycles(IDLE_GAP);

        write_byte(7'h15, 8'ha5, IDLE_GAP);
        read_and_check(7'h15, IDLE_GAP);

        // Abort after five data bits, old byte must survive
        write_byte(7'h2c, 8'h3c, IDLE_GAP);
        spi_xfer(1'b0, 7'h2c, 8'hc3, 13, unused);
        wait_cycles(IDLE_GAP);
        read_and_check(7'h2c, IDLE_GAP);

        // Sixteen addresses near the top so they repeat
        for (int n = 0; n < 32; n++) begin
            lcg_state = lcg_next(lcg_state);
            addr = 7'h7f ^ {3'b000, lcg_state[23:20]};
            if (lcg_state[29] && written[addr]) begin
                read_and_check(addr, IDLE_GAP);
            end else begin
                write_byte(addr, lcg_state[31:24], IDLE_GAP);
            end
        end

        write_byte(7'h7f, 8'h5a, MIN_GAP);
        read_and_check(7'h7f, MIN_GAP);
        write_byte(7'h00, 8'hc7, MIN_GAP);
        read_and_check(7'h00, MIN_GAP);
        read_and_check(7'h7f, MIN_GAP);
        write_byte(7'h7f, 8'h81, MIN_GAP);
        read_and_check(7'h7f, MIN_GAP);
        read_and_check(7'h15, IDLE_GAP);

        if (i_dut.i_fsm.i_asserts.fail_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("protocol assertion in the control FSM failed during the run");
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

//--- spi_memory.f
+incdir+src
src/spi_memory_pkg.sv
src/input_conditioner.sv
src/shift_register.sv
src/data_memory.sv
src/spi_control_fsm.sv
src/spi_memory.sv
tb/spi_memory_asserts.sv
tb/spi_memory_tb.sv
